//--- ethPkg.sv
package ethPkg;

	////////////////////////////////////////
	// Sizing
	////////////////////////////////////////

	localparam int NumSockets = 4;
	localparam int SockDepth = 64;
	localparam int SockIdW = 2;
	// One extra bit so a full store is distinct from an empty one
	localparam int SockPtrW = $clog2(SockDepth) + 1;
	localparam int DataLenW = 10;
	localparam logic [DataLenW-1:0] SockDepthLen = DataLenW'(SockDepth);

	////////////////////////////////////////
	// Protocol constants
	////////////////////////////////////////

	// Reflected CRC-32, bits taken LSB first
	localparam logic [31:0] CrcPoly = 32'hEDB88320;
	// Register value after a good frame plus its FCS
	localparam logic [31:0] CrcResidue = 32'hDEBB20E3;

	localparam logic [15:0] EtherIpv4 = 16'h0800;
	localparam logic [15:0] EtherArp = 16'h0806;
	localparam logic [15:0] ArpOpReq = 16'h0001;
	localparam logic [7:0] IpProtoIcmp = 8'd1;
	localparam logic [7:0] IpProtoUdp = 8'd17;
	localparam logic [7:0] IcmpEchoReq = 8'd8;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef enum logic [2:0] {
		pktUnknown = 3'd0,
		pktUdp = 3'd1,
		pktArpReq = 3'd2,
		pktIcmpReq = 3'd4
	} pktType_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} rxByte_t;

	typedef struct packed {
		pktType_t pktType;
		logic [47:0] fromMac;
		logic [31:0] fromIp;
		logic [15:0] fromPort;
		logic [15:0] icmpId;
		logic [15:0] icmpSeq;
		logic [DataLenW-1:0] dataLen;
		logic [SockIdW-1:0] sockId;
		logic crcOk;
	} frameInfo_t;

	typedef struct packed {
		logic [SockIdW-1:0] sockId;
		logic [7:0] data;
		logic last;
	} sockOut_t;

	typedef struct packed {
		logic [47:0] hostMac;
		logic [31:0] hostIp;
	} hostCfg_t;

	// Entry i is the UDP port bound to socket i
	typedef logic [NumSockets-1:0][15:0] portTable_t;

endpackage

//--- ethCrc32.sv
`timescale 1ns/1ps

module ethCrc32 (
	input  logic clk50,
	input  logic arstN,
	input  logic clear,
	input  logic byteEn,
	input  logic [7:0] byteIn,
	output logic residueOk
);

	logic [31:0] crc;

	// Eight serial steps folded into one byte
	function automatic logic [31:0] crcStep(input logic [31:0] crcIn, input logic [7:0] d);
		logic [31:0] c;
		c = crcIn;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i]) begin
				c = (c >> 1) ^ ethPkg::CrcPoly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge clk50 or negedge arstN) begin
		if (!arstN) begin
			crc <= '1;
		end else if (clear) begin
			crc <= '1;
		end else if (byteEn) begin
			crc <= crcStep(crc, byteIn);
		end
	end

	// FCS included, so a good frame leaves the fixed residue
	assign residueOk = (crc == ethPkg::CrcResidue);

endmodule

//--- ethFrameParser.sv
`timescale 1ns/1ps

module ethFrameParser (
	input  logic clk50,
	input  logic arstN,
	input  logic inReq,
	input  ethPkg::rxByte_t inData,
	output logic inAck,
	input  ethPkg::hostCfg_t hostCfg,
	input  ethPkg::portTable_t portTable,
	input  logic [ethPkg::NumSockets-1:0] sockBusy,
	output logic [ethPkg::NumSockets-1:0] sockWrEn,
	output logic [ethPkg::NumSockets-1:0] sockCommit,
	output logic [ethPkg::NumSockets-1:0] sockDiscard,
	output logic [7:0] sockWrData,
	output logic frameDone,
	output ethPkg::frameInfo_t frameInfo
);

	logic take;
	logic [7:0] rxData;
	logic [39:0] history;
	logic [47:0] win;
	logic [10:0] offset;
	logic endPending;
	logic residueOk;

	// Per-frame flags
	logic ignore;
	logic bcast;
	logic ipFlag;
	logic arpFlag;
	logic icmpFlag;
	logic udpFlag;
	logic claimed;
	ethPkg::pktType_t pktType;
	logic [ethPkg::SockIdW-1:0] sockSel;
	logic [ethPkg::DataLenW-1:0] dataLen;
	logic [ethPkg::DataLenW-1:0] payCnt;
	logic writeByte;
	logic accepted;

	// Captured header fields
	logic [47:0] fromMac;
	logic [31:0] fromIp;
	logic [15:0] fromPort;
	logic [15:0] icmpId;
	logic [15:0] icmpSeq;

	logic portHit;
	logic [ethPkg::SockIdW-1:0] portIdx;
	logic [15:0] udpPay;

	assign take = inReq && !inAck;
	assign rxData = inData.data;
	// Six most recent bytes, current one lowest
	assign win = {history, rxData};
	assign udpPay = win[15:0] - 16'd8;
	assign writeByte = take && !inData.last && claimed && offset >= 11'd42 && payCnt < dataLen;
	assign accepted = !ignore && pktType != ethPkg::pktUnknown;

	ethCrc32 uCrc (
		.clk50(clk50),
		.arstN(arstN),
		.clear(endPending),
		.byteEn(take),
		.byteIn(rxData),
		.residueOk(residueOk)
	);

	// Lowest matching table entry wins
	always_comb begin
		portHit = 1'b0;
		portIdx = '0;
		for (int i = ethPkg::NumSockets - 1; i >= 0; i--) begin
			if (portTable[i] == win[15:0]) begin
				portHit = 1'b1;
				portIdx = i[ethPkg::SockIdW-1:0];
			end
		end
	end

	////////////////////////////////////////
	// Input handshake and offset counter
	////////////////////////////////////////

	always_ff @(posedge clk50 or negedge arstN) begin
		if (!arstN) begin
			inAck <= 1'b0;
			endPending <= 1'b0;
			offset <= '0;
		end else begin
			endPending <= take && inData.last;
			if (take) begin
				inAck <= 1'b1;
			end else if (!inReq) begin
				inAck <= 1'b0;
			end
			if (take && inData.last) begin
				offset <= '0;
			end else if (take && offset != '1) begin
				offset <= offset + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Filter and classification
	////////////////////////////////////////

	always_ff @(posedge clk50 or negedge arstN) begin
		if (!arstN) begin
			ignore <= 1'b0;
			bcast <= 1'b0;
			ipFlag <= 1'b0;
			arpFlag <= 1'b0;
			icmpFlag <= 1'b0;
			udpFlag <= 1'b0;
			claimed <= 1'b0;
			pktType <= ethPkg::pktUnknown;
			sockSel <= '0;
			dataLen <= '0;
			payCnt <= '0;
			sockWrEn <= '0;
		end else begin
			sockWrEn <= '0;
			if (writeByte) begin
				sockWrEn[sockSel] <= 1'b1;
				payCnt <= payCnt + 1'b1;
			end
			if (endPending) begin
				ignore <= 1'b0;
				bcast <= 1'b0;
				ipFlag <= 1'b0;
				arpFlag <= 1'b0;
				icmpFlag <= 1'b0;
				udpFlag <= 1'b0;
				claimed <= 1'b0;
				pktType <= ethPkg::pktUnknown;
				dataLen <= '0;
				payCnt <= '0;
			end else if (take && !ignore) begin
				case (offset)
					11'd5: begin
						if (win == '1) begin
							bcast <= 1'b1;
						end else if (win != hostCfg.hostMac) begin
							ignore <= 1'b1;
						end
					end
					11'd13: begin
						if (win[15:0] == ethPkg::EtherIpv4) begin
							ipFlag <= 1'b1;
						end else if (win[15:0] == ethPkg::EtherArp) begin
							arpFlag <= 1'b1;
						end else begin
							ignore <= 1'b1;
						end
					end
					// ARP requests only count when broadcast
					11'd21: begin
						if (arpFlag && !(bcast && win[15:0] == ethPkg::ArpOpReq)) begin
							ignore <= 1'b1;
						end
					end
					11'd23: begin
						if (ipFlag) begin
							if (rxData == ethPkg::IpProtoIcmp) begin
								icmpFlag <= 1'b1;
							end else if (rxData == ethPkg::IpProtoUdp) begin
								udpFlag <= 1'b1;
							end else begin
								ignore <= 1'b1;
							end
						end
					end
					11'd33: begin
						if (ipFlag && win[31:0] != hostCfg.hostIp) begin
							ignore <= 1'b1;
						end
					end
					11'd34: begin
						if (icmpFlag && rxData == ethPkg::IcmpEchoReq) begin
							pktType <= ethPkg::pktIcmpReq;
						end else if (icmpFlag) begin
							ignore <= 1'b1;
						end
					end
					// Socket claimed here, busy socket drops the whole frame
					11'd37: begin
						if (udpFlag && portHit && !sockBusy[portIdx]) begin
							pktType <= ethPkg::pktUdp;
							sockSel <= portIdx;
							claimed <= 1'b1;
						end else if (udpFlag) begin
							ignore <= 1'b1;
						end
					end
					11'd39: begin
						if (udpFlag && win[15:0] < 16'd8) begin
							dataLen <= '0;
						end else if (udpFlag && (udpPay[15:ethPkg::DataLenW] != '0 ||
								udpPay[ethPkg::DataLenW-1:0] > ethPkg::SockDepthLen)) begin
							dataLen <= ethPkg::SockDepthLen;
						end else if (udpFlag) begin
							dataLen <= udpPay[ethPkg::DataLenW-1:0];
						end
					end
					11'd41: begin
						if (arpFlag && win[31:0] == hostCfg.hostIp) begin
							pktType <= ethPkg::pktArpReq;
						end else if (arpFlag) begin
							ignore <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Header captures and payload byte
	always_ff @(posedge clk50) begin
		if (writeByte) begin
			sockWrData <= rxData;
		end
		if (take) begin
			history <= win[39:0];
			case (offset)
				11'd11: fromMac <= win;
				11'd27: if (arpFlag) fromMac <= win;
				11'd29: if (ipFlag) fromIp <= win[31:0];
				11'd31: if (arpFlag) fromIp <= win[31:0];
				11'd35: fromPort <= win[15:0];
				11'd39: icmpId <= win[15:0];
				11'd41: icmpSeq <= win[15:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Frame end
	////////////////////////////////////////

	always_comb begin
		sockCommit = '0;
		sockDiscard = '0;
		if (endPending && claimed) begin
			if (accepted && residueOk) begin
				sockCommit[sockSel] = 1'b1;
			end else begin
				sockDiscard[sockSel] = 1'b1;
			end
		end
	end

	assign frameDone = endPending && accepted;

	always_comb begin
		frameInfo.pktType = pktType;
		frameInfo.fromMac = fromMac;
		frameInfo.fromIp = fromIp;
		frameInfo.fromPort = fromPort;
		frameInfo.icmpId = icmpId;
		frameInfo.icmpSeq = icmpSeq;
		frameInfo.dataLen = dataLen;
		frameInfo.sockId = sockSel;
		frameInfo.crcOk = residueOk;
	end

	// Source must wait for our ack before withdrawing a byte
	aReqHeld: assert property (@(posedge clk50) disable iff (!arstN)
		$fell(inReq) |-> $past(inAck))
		else $error("inReq dropped before inAck");

endmodule

//--- sockBuffer.sv
`timescale 1ns/1ps

module sockBuffer (
	input  logic clk50,
	input  logic arstN,
	input  logic wrEn,
	input  logic commit,
	input  logic discard,
	input  logic [7:0] wrData,
	output logic busy,
	output logic dgReady,
	input  logic rdPop,
	output logic [7:0] rdData,
	output logic rdLast
);

	logic [7:0] mem [ethPkg::SockDepth];
	logic [ethPkg::SockPtrW-1:0] wrPtr;
	logic [ethPkg::SockPtrW-1:0] rdPtr;
	logic full;

	// Top pointer bit set means all SockDepth bytes used
	assign full = wrPtr[ethPkg::SockPtrW-1];

	assign rdData = mem[rdPtr[ethPkg::SockPtrW-2:0]];
	assign rdLast = (rdPtr + 1'b1 == wrPtr);

	always_ff @(posedge clk50) begin
		if (wrEn && !full) begin
			mem[wrPtr[ethPkg::SockPtrW-2:0]] <= wrData;
		end
	end

	always_ff @(posedge clk50 or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			busy <= 1'b0;
			dgReady <= 1'b0;
		end else begin
			if (wrEn && !full) begin
				wrPtr <= wrPtr + 1'b1;
				busy <= 1'b1;
			end
			// Partial datagram thrown away
			if (discard) begin
				wrPtr <= '0;
				busy <= 1'b0;
			end else if (commit && wrPtr != '0) begin
				dgReady <= 1'b1;
			end
			if (rdPop && rdLast) begin
				rdPtr <= '0;
				wrPtr <= '0;
				dgReady <= 1'b0;
				busy <= 1'b0;
			end else if (rdPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	// Parser has to respect busy before writing
	aNoWriteWhileReady: assert property (@(posedge clk50) disable iff (!arstN)
		wrEn |-> !dgReady)
		else $error("Write into a committed socket");

	// Arbiter only drains committed datagrams
	aPopOnlyReady: assert property (@(posedge clk50) disable iff (!arstN)
		rdPop |-> dgReady)
		else $error("Pop from a socket with no datagram");

endmodule

//--- sockArbiter.sv
`timescale 1ns/1ps

module sockArbiter (
	input  logic clk50,
	input  logic arstN,
	input  logic [ethPkg::NumSockets-1:0] dgReady,
	input  logic [ethPkg::NumSockets-1:0][7:0] rdData,
	input  logic [ethPkg::NumSockets-1:0] rdLast,
	output logic [ethPkg::NumSockets-1:0] rdPop,
	output logic outReq,
	output ethPkg::sockOut_t outData,
	input  logic outAck
);

	typedef enum logic [1:0] {
		sIdle,
		sLoad,
		sHold,
		sDrop
	} state_t;

	state_t state;
	logic [ethPkg::SockIdW-1:0] cur;
	logic [ethPkg::SockIdW-1:0] rrPtr;
	logic [ethPkg::SockIdW-1:0] pick;
	logic found;

	// First ready socket at or after rrPtr, index wraps with its width
	always_comb begin
		logic [ethPkg::SockIdW-1:0] idx;
		found = 1'b0;
		pick = rrPtr;
		for (int i = 0; i < ethPkg::NumSockets; i++) begin
			idx = rrPtr + i[ethPkg::SockIdW-1:0];
			if (!found && dgReady[idx]) begin
				found = 1'b1;
				pick = idx;
			end
		end
	end

	// Byte leaves the socket once the sink has taken it
	always_comb begin
		rdPop = '0;
		if (state == sHold && outAck) begin
			rdPop[cur] = 1'b1;
		end
	end

	always_ff @(posedge clk50 or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			cur <= '0;
			rrPtr <= '0;
			outReq <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					if (found) begin
						cur <= pick;
						state <= sLoad;
					end
				end
				sLoad: begin
					outReq <= 1'b1;
					state <= sHold;
				end
				sHold: begin
					if (outAck) begin
						outReq <= 1'b0;
						state <= sDrop;
					end
				end
				// Wait for ack low before the next byte or release
				sDrop: begin
					if (!outAck && outData.last) begin
						rrPtr <= cur + 1'b1;
						state <= sIdle;
					end else if (!outAck) begin
						state <= sLoad;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (state == sLoad) begin
			outData.sockId <= cur;
			outData.data <= rdData[cur];
			outData.last <= rdLast[cur];
		end
	end

	aPopOneReady: assert property (@(posedge clk50) disable iff (!arstN)
		$onehot0(rdPop) && ((rdPop & ~dgReady) == '0))
		else $error("rdPop not one-hot to a ready socket");

endmodule

//--- ethRxTop.sv
`timescale 1ns/1ps

module ethRxTop (
	input  logic clk50,
	input  logic arstN,
	input  logic inReq,
	input  ethPkg::rxByte_t inData,
	output logic inAck,
	input  ethPkg::hostCfg_t hostCfg,
	input  ethPkg::portTable_t portTable,
	output logic frameDone,
	output ethPkg::frameInfo_t frameInfo,
	output logic outReq,
	output ethPkg::sockOut_t outData,
	input  logic outAck
);

	// Parser to sockets
	logic [ethPkg::NumSockets-1:0] sockBusy;
	logic [ethPkg::NumSockets-1:0] sockWrEn;
	logic [ethPkg::NumSockets-1:0] sockCommit;
	logic [ethPkg::NumSockets-1:0] sockDiscard;
	logic [7:0] sockWrData;

	// Sockets to arbiter
	logic [ethPkg::NumSockets-1:0] dgReady;
	logic [ethPkg::NumSockets-1:0][7:0] rdData;
	logic [ethPkg::NumSockets-1:0] rdLast;
	logic [ethPkg::NumSockets-1:0] rdPop;

	ethFrameParser uParser (
		.clk50(clk50),
		.arstN(arstN),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.hostCfg(hostCfg),
		.portTable(portTable),
		.sockBusy(sockBusy),
		.sockWrEn(sockWrEn),
		.sockCommit(sockCommit),
		.sockDiscard(sockDiscard),
		.sockWrData(sockWrData),
		.frameDone(frameDone),
		.frameInfo(frameInfo)
	);

	generate
		for (genvar g = 0; g < ethPkg::NumSockets; g++) begin : gSock
			sockBuffer uBuf (
				.clk50(clk50),
				.arstN(arstN),
				.wrEn(sockWrEn[g]),
				.commit(sockCommit[g]),
				.discard(sockDiscard[g]),
				.wrData(sockWrData),
				.busy(sockBusy[g]),
				.dgReady(dgReady[g]),
				.rdPop(rdPop[g]),
				.rdData(rdData[g]),
				.rdLast(rdLast[g])
			);
		end
	endgenerate

	sockArbiter uArb (
		.clk50(clk50),
		.arstN(arstN),
		.dgReady(dgReady),
		.rdData(rdData),
		.rdLast(rdLast),
		.rdPop(rdPop),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

endmodule

//--- tbEthRx.sv
`timescale 1ns/1ps

module tbEthRx;

	// Endpoint and far side addresses
	localparam logic [47:0] HostMac = 48'h02_00_5E_10_00_01;
	localparam logic [31:0] HostIp = 32'hC0A8_0164;
	localparam logic [47:0] PeerMac = 48'h02_00_5E_20_00_07;
	localparam logic [31:0] PeerIp = 32'hC0A8_0105;
	localparam logic [15:0] PeerPort = 16'd40000;
	localparam logic [47:0] ArpSenderMac = 48'h02_AA_BB_CC_DD_EE;
	localparam logic [15:0] BasePort = 16'd5000;

	// Frame bytes of each test in order with FCS
	localparam int FrameBytes = 66 + 124 + 92 + 50 + 154 + 224;
	localparam int WatchdogCycles = FrameBytes * 40 + 2000;

	logic clk50;
	logic arstN;
	logic inReq;
	ethPkg::rxByte_t inData;
	logic inAck;
	ethPkg::hostCfg_t hostCfg;
	ethPkg::portTable_t portTable;
	logic frameDone;
	ethPkg::frameInfo_t frameInfo;
	logic outReq;
	ethPkg::sockOut_t outData;
	logic outAck;

	logic [7:0] frame [$];
	logic [7:0] expPay [$];
	ethPkg::sockOut_t expOut [$];
	ethPkg::sockOut_t outQ [$];
	ethPkg::frameInfo_t repQ [$];
	logic [15:0] lfsr;
	logic ackEnable;
	int ackDelay;
	int errors;
	int checks;

	ethRxTop dut (
		.clk50(clk50),
		.arstN(arstN),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.hostCfg(hostCfg),
		.portTable(portTable),
		.frameDone(frameDone),
		.frameInfo(frameInfo),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	initial begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;
	end

	always @(posedge clk50) begin
		if (arstN && frameDone) begin
			repQ.push_back(frameInfo);
		end
	end

	// Output sink acks each byte after ackDelay cycles
	initial begin
		int waitCnt;
		waitCnt = 0;
		forever begin
			@(posedge clk50);
			if (outReq && !outAck && ackEnable) begin
				if (waitCnt < ackDelay) begin
					waitCnt++;
				end else begin
					waitCnt = 0;
					outQ.push_back(outData);
					outAck <= 1'b1;
				end
			end else if (!outReq && outAck) begin
				outAck <= 1'b0;
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk50);
		$display("Watchdog expired after %0d cycles with a test still running", WatchdogCycles);
		$display("Checks failed");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic expectEq(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [7:0] randByte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[15];
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
		return b;
	endfunction

	// Ethernet FCS over the frame built so far
	function automatic logic [31:0] frameFcs();
		logic [31:0] c;
		c = '1;
		foreach (frame[i]) begin
			c = c ^ {24'h0, frame[i]};
			for (int k = 0; k < 8; k++) begin
				c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	task automatic put8(input logic [7:0] b);
		frame.push_back(b);
	endtask

	task automatic put16(input logic [15:0] v);
		put8(v[15:8]);
		put8(v[7:0]);
	endtask

	task automatic put32(input logic [31:0] v);
		put16(v[31:16]);
		put16(v[15:0]);
	endtask

	task automatic put48(input logic [47:0] v);
		put16(v[47:32]);
		put32(v[31:0]);
	endtask

	task automatic putEthHeader(input logic [47:0] dstMac, input logic [15:0] etherType);
		frame.delete();
		put48(dstMac);
		put48(PeerMac);
		put16(etherType);
	endtask

	// IPv4 header without options ending at offset 33
	task automatic putIpHeader(input logic [47:0] dstMac, input logic [7:0] proto,
			input logic [31:0] dstIp, input logic [15:0] totalLen);
		putEthHeader(dstMac, 16'h0800);
		put16(16'h4500);
		put16(totalLen);
		put32(32'h0000_4000);
		put8(8'd64);
		put8(proto);
		put16(16'h0000);
		put32(PeerIp);
		put32(dstIp);
	endtask

	task automatic buildUdp(input logic [47:0] dstMac, input logic [15:0] dstPort,
			input int payLen);
		logic [7:0] b;
		putIpHeader(dstMac, 8'd17, HostIp, 16'(payLen + 28));
		put16(PeerPort);
		put16(dstPort);
		put16(16'(payLen + 8));
		put16(16'h0000);
		expPay.delete();
		for (int i = 0; i < payLen; i++) begin
			b = randByte();
			put8(b);
			expPay.push_back(b);
		end
	endtask

	task automatic buildArp(input logic [31:0] targetIp);
		putEthHeader(48'hFFFF_FFFF_FFFF, 16'h0806);
		put16(16'h0001);
		put16(16'h0800);
		put8(8'd6);
		put8(8'd4);
		put16(16'h0001);
		put48(ArpSenderMac);
		put32(PeerIp);
		put48(48'h0);
		put32(targetIp);
	endtask

	// One four-phase transfer on the input link
	task automatic sendByte(input logic [7:0] b, input logic last);
		inReq <= 1'b1;
		inData.data <= b;
		inData.last <= last;
		do begin
			@(posedge clk50);
		end while (!inAck);
		inReq <= 1'b0;
		do begin
			@(posedge clk50);
		end while (inAck);
	endtask

	task automatic sendFrame(input logic corrupt);
		logic [31:0] fcs;
		fcs = frameFcs();
		// FCS goes out low byte first
		put32({fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]});
		if (corrupt) begin
			frame[frame.size() - 1] = frame[frame.size() - 1] ^ 8'h5A;
		end
		for (int i = 0; i < frame.size(); i++) begin
			sendByte(frame[i], i == frame.size() - 1);
		end
	endtask

	task automatic expectDatagram(input int sock);
		ethPkg::sockOut_t o;
		for (int i = 0; i < expPay.size(); i++) begin
			o.sockId = sock[ethPkg::SockIdW-1:0];
			o.data = expPay[i];
			o.last = (i == expPay.size() - 1);
			expOut.push_back(o);
		end
	endtask

	task automatic popReport(input string what, output ethPkg::frameInfo_t r, output logic got);
		int t;
		t = 0;
		while (repQ.size() == 0 && t < 50) begin
			@(posedge clk50);
			t++;
		end
		checks++;
		got = (repQ.size() != 0);
		r = '0;
		if (got) begin
			r = repQ.pop_front();
		end else begin
			errors++;
			$display("No frameDone report for the %s frame", what);
		end
	endtask

	task automatic expectNoReport(input string what);
		repeat (40) @(posedge clk50);
		checks++;
		if (repQ.size() != 0) begin
			errors++;
			$display("Unexpected frameDone report for the %s frame", what);
			repQ.delete();
		end
	endtask

	task automatic checkUdpReport(input ethPkg::frameInfo_t r, input int len, input int sock,
			input logic crcOk);
		expectEq("frameInfo.pktType", 64'(ethPkg::pktUdp), 64'(r.pktType));
		expectEq("frameInfo.fromMac", 64'(PeerMac), 64'(r.fromMac));
		expectEq("frameInfo.fromIp", 64'(PeerIp), 64'(r.fromIp));
		expectEq("frameInfo.fromPort", 64'(PeerPort), 64'(r.fromPort));
		expectEq("frameInfo.dataLen", 64'(len), 64'(r.dataLen));
		expectEq("frameInfo.sockId", 64'(sock), 64'(r.sockId));
		expectEq("frameInfo.crcOk", 64'(crcOk), 64'(r.crcOk));
	endtask

	// Compares collected output with expOut and empties both
	task automatic checkOutput(input string what);
		int t;
		int n;
		t = 0;
		n = expOut.size();
		while (outQ.size() < n && t < n * 40 + 200) begin
			@(posedge clk50);
			t++;
		end
		// Time for a stray extra byte to show up
		repeat (60) @(posedge clk50);
		checks++;
		if (outQ.size() != n) begin
			errors++;
			$display("%s: expected %0d output bytes, collected %0d", what, n, outQ.size());
		end
		for (int i = 0; i < n && i < outQ.size(); i++) begin
			expectEq($sformatf("outData.sockId[%0d]", i), 64'(expOut[i].sockId),
				64'(outQ[i].sockId));
			expectEq($sformatf("outData.data[%0d]", i), 64'(expOut[i].data), 64'(outQ[i].data));
			expectEq($sformatf("outData.last[%0d]", i), 64'(expOut[i].last), 64'(outQ[i].last));
		end
		expOut.delete();
		outQ.delete();
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic testUdpDelivery();
		ethPkg::frameInfo_t r;
		logic got;
		buildUdp(HostMac, BasePort + 16'd2, 20);
		sendFrame(1'b0);
		expectDatagram(2);
		popReport("UDP", r, got);
		if (got) begin
			checkUdpReport(r, 20, 2, 1'b1);
		end
		checkOutput("UDP delivery");
	endtask

	task automatic testBadCrc();
		ethPkg::frameInfo_t r;
		logic got;
		buildUdp(HostMac, BasePort + 16'd2, 20);
		sendFrame(1'b1);
		popReport("corrupted UDP", r, got);
		if (got) begin
			checkUdpReport(r, 20, 2, 1'b0);
		end
		checkOutput("bad CRC frame");
		// Socket 2 must be free again after the discard
		buildUdp(HostMac, BasePort + 16'd2, 12);
		sendFrame(1'b0);
		expectDatagram(2);
		popReport("UDP after bad CRC", r, got);
		if (got) begin
			checkUdpReport(r, 12, 2, 1'b1);
		end
		checkOutput("good frame after bad CRC");
	endtask

	task automatic testArpRequest();
		ethPkg::frameInfo_t r;
		logic got;
		buildArp(HostIp);
		sendFrame(1'b0);
		popReport("ARP request", r, got);
		if (got) begin
			expectEq("frameInfo.pktType", 64'(ethPkg::pktArpReq), 64'(r.pktType));
			expectEq("frameInfo.fromMac", 64'(ArpSenderMac), 64'(r.fromMac));
			expectEq("frameInfo.fromIp", 64'(PeerIp), 64'(r.fromIp));
			expectEq("frameInfo.crcOk", 64'(1'b1), 64'(r.crcOk));
		end
		buildArp(HostIp ^ 32'h0000_0001);
		sendFrame(1'b0);
		expectNoReport("ARP for another host");
	endtask

	task automatic testIcmpEcho();
		ethPkg::frameInfo_t r;
		logic got;
		putIpHeader(HostMac, 8'd1, HostIp, 16'd32);
		put8(8'd8);
		put8(8'd0);
		put16(16'h0000);
		put16(16'h1234);
		put16(16'h0042);
		put32(32'hDEAD_BEEF);
		sendFrame(1'b0);
		popReport("ICMP echo", r, got);
		if (got) begin
			expectEq("frameInfo.pktType", 64'(ethPkg::pktIcmpReq), 64'(r.pktType));
			expectEq("frameInfo.fromIp", 64'(PeerIp), 64'(r.fromIp));
			expectEq("frameInfo.icmpId", 64'(16'h1234), 64'(r.icmpId));
			expectEq("frameInfo.icmpSeq", 64'(16'h0042), 64'(r.icmpSeq));
		end
		checkOutput("ICMP echo");
	endtask

	task automatic testFiltering();
		buildUdp(48'h02_11_22_33_44_55, BasePort, 8);
		sendFrame(1'b0);
		expectNoReport("foreign MAC");
		buildUdp(HostMac, 16'd9999, 8);
		sendFrame(1'b0);
		expectNoReport("unbound port");
		putEthHeader(HostMac, 16'h88B5);
		for (int i = 0; i < 28; i++) begin
			put8(8'(i));
		end
		sendFrame(1'b0);
		expectNoReport("unknown EtherType");
		checkOutput("filtered frames");
	endtask

	task automatic testRoundRobin();
		ethPkg::frameInfo_t r;
		logic got;
		ackEnable <= 1'b0;
		// Arbiter locks onto 3 while it is the only ready socket and resumes at 0
		buildUdp(HostMac, BasePort + 16'd3, 10);
		sendFrame(1'b0);
		expectDatagram(3);
		popReport("socket 3", r, got);
		if (got) begin
			checkUdpReport(r, 10, 3, 1'b1);
		end
		buildUdp(HostMac, BasePort, 6);
		sendFrame(1'b0);
		expectDatagram(0);
		popReport("socket 0", r, got);
		if (got) begin
			checkUdpReport(r, 6, 0, 1'b1);
		end
		buildUdp(HostMac, BasePort + 16'd1, 16);
		sendFrame(1'b0);
		expectDatagram(1);
		popReport("socket 1", r, got);
		if (got) begin
			checkUdpReport(r, 16, 1, 1'b1);
		end
		// Socket 0 still holds its datagram
		buildUdp(HostMac, BasePort, 8);
		sendFrame(1'b0);
		expectNoReport("busy socket 0");
		ackEnable <= 1'b1;
		checkOutput("round robin");
	endtask

	initial begin
		arstN = 1'b0;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		hostCfg.hostMac = HostMac;
		hostCfg.hostIp = HostIp;
		for (int i = 0; i < ethPkg::NumSockets; i++) begin
			portTable[i] = BasePort + 16'(i);
		end
		ackEnable = 1'b1;
		ackDelay = 2;
		lfsr = 16'd96;
		errors = 0;
		checks = 0;
		repeat (3) @(posedge clk50);
		arstN <= 1'b1;
		@(posedge clk50);
		expectEq("inAck", 64'(1'b0), 64'(inAck));
		expectEq("outReq", 64'(1'b0), 64'(outReq));
		expectEq("frameDone", 64'(1'b0), 64'(frameDone));
		testUdpDelivery();
		testBadCrc();
		testArpRequest();
		testIcmpEcho();
		testFiltering();
		testRoundRobin();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
ethPkg.sv
ethCrc32.sv
ethFrameParser.sv
sockBuffer.sv
sockArbiter.sv
ethRxTop.sv
tbEthRx.sv

//--- Makefile
TOOL      = verilator
LINTFLAGS = --lint-only -Wall --timing
SIMFLAGS  = --binary --timing --assert -j 0
TOP       = tbEthRx
RTL_TOP   = ethRxTop
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed
FAIL_MSG  = Checks failed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
